/* src/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus geometry
`define SOC_WB_AW 32
`define SOC_WB_DW 32

// on-chip ram size in words
`define SOC_RAM_DEPTH 512

// region codes, compared against adr[15:12]
`define SOC_REGION_RAM 4'h0
`define SOC_REGION_CSR 4'h1

// csr field widths
`define SOC_PRESC_W     4
`define SOC_OLED_SIZE_W 14
`define SOC_GPIO_W      8

`endif

/* src/soc_pkg.sv */
`include "soc_params.svh"

package soc_pkg;

  // wishbone payload types
  typedef logic [`SOC_WB_AW-1:0]   wb_adr_t;
  typedef logic [`SOC_WB_DW-1:0]   wb_dat_t;
  typedef logic [`SOC_WB_DW/8-1:0] wb_sel_t;

  // oled link config
  typedef logic [`SOC_PRESC_W-1:0]     presc_t;
  typedef logic [`SOC_OLED_SIZE_W-1:0] oled_size_t;

  // gpio port value
  typedef logic [`SOC_GPIO_W-1:0] gpio_t;

  // word offsets inside the csr region, adr[4:2]
  typedef enum logic [2:0] {
    CSR_GPO       = 3'd0,
    CSR_GPI       = 3'd1,
    CSR_OLED_CONF = 3'd2,
    CSR_OLED_ADDR = 3'd3,
    CSR_OLED_SIZE = 3'd4,
    CSR_OLED_CTRL = 3'd5
  } csr_idx_e;

endpackage

/* src/wb_if.sv */
`timescale 1ns/1ns

interface wb_if;

  import soc_pkg::*;

  // classic cycle, no stall, no err/rty
  logic    cyc;
  logic    stb;
  logic    we;
  wb_sel_t sel;
  wb_adr_t adr;
  wb_dat_t wdat;
  wb_dat_t rdat;
  logic    ack;

  // request side
  modport master (output cyc, stb, we, sel, adr, wdat, input rdat, ack);

  // response side
  modport slave (input cyc, stb, we, sel, adr, wdat, output rdat, ack);

endinterface

/* src/wb_intercon.sv */
`timescale 1ns/1ns
`include "soc_params.svh"

module wb_intercon (
  input  logic clk_i,
  input  logic arst_n_i,
  wb_if.slave  host,
  wb_if.slave  dma,
  wb_if.master ram,
  wb_if.master csr
);

  import soc_pkg::*;

  //##########################################################################
  // arbitration
  //##########################################################################

  // grant is latched on the first cycle and held until owner cyc falls
  logic    lock_q;
  logic    gnt_dma_q;
  logic    gnt_dma;
  logic    err_ack_q;
  // owner request after the mux
  logic    req_cyc;
  logic    req_stb;
  logic    req_we;
  wb_sel_t req_sel;
  wb_adr_t req_adr;
  wb_dat_t req_wdat;
  // region hits
  logic    sel_ram;
  logic    sel_csr;
  logic    slv_ack;
  wb_dat_t slv_rdat;

  // idle bus picks dma first, host otherwise
  assign gnt_dma  = lock_q ? gnt_dma_q : dma.cyc;
  assign req_cyc  = gnt_dma ? dma.cyc  : host.cyc;
  assign req_stb  = gnt_dma ? dma.stb  : host.stb;
  assign req_we   = gnt_dma ? dma.we   : host.we;
  assign req_sel  = gnt_dma ? dma.sel  : host.sel;
  assign req_adr  = gnt_dma ? dma.adr  : host.adr;
  assign req_wdat = gnt_dma ? dma.wdat : host.wdat;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q    <= 1'b0;
      gnt_dma_q <= 1'b0;
      err_ack_q <= 1'b0;
    end else begin
      if (!lock_q) begin
        lock_q    <= req_cyc;
        gnt_dma_q <= dma.cyc;
      end else if (!req_cyc) begin
        // release, next master gets the bus one cycle later
        lock_q <= 1'b0;
      end
      // unmapped region, answer locally, data zero, write dropped
      err_ack_q <= req_cyc & req_stb & ~sel_ram & ~sel_csr & ~err_ack_q;
    end
  end

  //##########################################################################
  // address decode and response mux
  //##########################################################################

  assign sel_ram = (req_adr[15:12] == `SOC_REGION_RAM);
  assign sel_csr = (req_adr[15:12] == `SOC_REGION_CSR);

  assign ram.cyc  = req_cyc & sel_ram;
  assign ram.stb  = req_stb & sel_ram;
  assign ram.we   = req_we;
  assign ram.sel  = req_sel;
  assign ram.adr  = req_adr;
  assign ram.wdat = req_wdat;

  assign csr.cyc  = req_cyc & sel_csr;
  assign csr.stb  = req_stb & sel_csr;
  assign csr.we   = req_we;
  assign csr.sel  = req_sel;
  assign csr.adr  = req_adr;
  assign csr.wdat = req_wdat;

  assign slv_ack  = sel_ram ? ram.ack  : (sel_csr ? csr.ack  : err_ack_q);
  assign slv_rdat = sel_ram ? ram.rdat : (sel_csr ? csr.rdat : '0);

  // ack goes only to the owner
  assign dma.ack   = gnt_dma & slv_ack;
  assign host.ack  = ~gnt_dma & slv_ack;
  assign dma.rdat  = slv_rdat;
  assign host.rdat = slv_rdat;

  // owner cannot be swapped in the middle of its cycle
  a_gnt_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_cyc |=> gnt_dma == $past(gnt_dma));

  // never two slaves strobed at once
  a_one_slave: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ram.stb, csr.stb}));

endmodule

/* src/wb_ram.sv */
`timescale 1ns/1ns
`include "soc_params.svh"

module wb_ram (
  input  logic clk_i,
  input  logic arst_n_i,
  wb_if.slave  bus
);

  // word index width, adr[IDX_W+1:2]
  localparam int unsigned IDX_W = $clog2(`SOC_RAM_DEPTH);

  logic [`SOC_WB_DW-1:0] mem_q [`SOC_RAM_DEPTH];
  logic [IDX_W-1:0]      idx;
  logic                  req;
  logic                  ack_q;
  logic [`SOC_WB_DW-1:0] rdat_q;

  assign idx = bus.adr[IDX_W+1:2];
  // new request only while no ack pending
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // storage and read port
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (bus.we) begin
        // byte lanes honored one by one
        for (int b = 0; b < `SOC_WB_DW/8; b++) begin
          if (bus.sel[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdat[8*b +: 8];
          end
        end
      end
      rdat_q <= mem_q[idx];
    end
  end

  assign bus.ack  = ack_q;
  assign bus.rdat = rdat_q;

  // single-cycle ack, master must drop stb after it
  a_ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus.ack |=> !bus.ack);

endmodule

/* src/csr_regs.sv */
`timescale 1ns/1ns
`include "soc_params.svh"

module csr_regs (
  input  logic                clk_i,
  input  logic                arst_n_i,
  wb_if.slave                 bus,
  input  soc_pkg::gpio_t      gpi_i,
  output soc_pkg::gpio_t      gpo_o,
  output logic                oled_start_o,
  output soc_pkg::presc_t     oled_presc_o,
  output logic                oled_inc_o,
  output soc_pkg::wb_adr_t    oled_adr_o,
  output soc_pkg::oled_size_t oled_size_o,
  input  logic                oled_rdy_i
);

  import soc_pkg::*;

  csr_idx_e   idx;
  logic       req;
  logic       ack_q;
  wb_dat_t    rdat_q;
  // register file
  gpio_t      gpo_q;
  presc_t     presc_q;
  logic       inc_q;
  wb_adr_t    adr_q;
  oled_size_t size_q;
  logic       start_q;

  assign idx = csr_idx_e'(bus.adr[4:2]);
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q   <= 1'b0;
      gpo_q   <= '0;
      presc_q <= '0;
      inc_q   <= 1'b0;
      adr_q   <= '0;
      size_q  <= '0;
      start_q <= 1'b0;
    end else begin
      ack_q <= req;
      // start is a one-cycle pulse, busy check is left to the dma
      start_q <= req & bus.we & (idx == CSR_OLED_CTRL) & bus.wdat[0];
      if (req && bus.we) begin
        // whole word written, fields keep their low bits
        case (idx)
          CSR_GPO: gpo_q <= gpio_t'(bus.wdat);
          CSR_OLED_CONF: begin
            presc_q <= presc_t'(bus.wdat);
            inc_q   <= bus.wdat[`SOC_PRESC_W];
          end
          CSR_OLED_ADDR: adr_q  <= bus.wdat;
          CSR_OLED_SIZE: size_q <= oled_size_t'(bus.wdat);
          default: ;
        endcase
      end
    end
  end

  // read mux, sampled with the request
  always_ff @(posedge clk_i) begin
    if (req) begin
      case (idx)
        CSR_GPO:       rdat_q <= wb_dat_t'(gpo_q);
        CSR_GPI:       rdat_q <= wb_dat_t'(gpi_i);
        CSR_OLED_CONF: rdat_q <= wb_dat_t'({inc_q, presc_q});
        CSR_OLED_ADDR: rdat_q <= adr_q;
        CSR_OLED_SIZE: rdat_q <= wb_dat_t'(size_q);
        CSR_OLED_CTRL: rdat_q <= wb_dat_t'(oled_rdy_i);
        default:       rdat_q <= '0;
      endcase
    end
  end

  assign bus.ack      = ack_q;
  assign bus.rdat     = rdat_q;
  assign gpo_o        = gpo_q;
  assign oled_start_o = start_q;
  assign oled_presc_o = presc_q;
  assign oled_inc_o   = inc_q;
  assign oled_adr_o   = adr_q;
  assign oled_size_o  = size_q;

endmodule

/* src/oled_dma_fsm.sv */
`timescale 1ns/1ns

module oled_dma_fsm (
  input  logic                clk_i,
  input  logic                arst_n_i,
  wb_if.master                bus,
  input  logic                start_i,
  input  logic                inc_i,
  input  soc_pkg::wb_adr_t    adr_i,
  input  soc_pkg::oled_size_t size_i,
  output logic                rdy_o,
  output logic                byte_start_o,
  input  logic                byte_done_i,
  output logic                word_load_o,
  output logic                next_byte_o,
  input  logic                word_end_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {IDLE, FETCH, SEND, WAIT_BYTE} state_e;

  state_e     state_q;
  // ram word index and bytes still to send
  wb_adr_t    adr_q;
  oled_size_t cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      adr_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // zero size is a no-op, rdy stays up
          if (start_i && size_i != '0) begin
            adr_q   <= adr_i;
            cnt_q   <= size_i;
            state_q <= FETCH;
          end
        end
        FETCH: begin
          if (bus.ack) begin
            // word goes into the serializer this cycle
            if (inc_i) begin
              adr_q <= adr_q + 1'b1;
            end
            state_q <= SEND;
          end
        end
        SEND: state_q <= WAIT_BYTE;
        WAIT_BYTE: begin
          if (byte_done_i) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == oled_size_t'(1)) state_q <= IDLE;
            else if (word_end_i)          state_q <= FETCH;
            else                          state_q <= SEND;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // read-only master, one word per cycle
  assign bus.cyc  = (state_q == FETCH);
  assign bus.stb  = (state_q == FETCH);
  assign bus.we   = 1'b0;
  assign bus.sel  = '1;
  assign bus.adr  = adr_q << 2;
  assign bus.wdat = '0;

  assign rdy_o        = (state_q == IDLE);
  assign word_load_o  = (state_q == FETCH) & bus.ack;
  // byte handed to the shifter and timer kicked together
  assign next_byte_o  = (state_q == SEND);
  assign byte_start_o = (state_q == SEND);

  // no bus traffic, and no stray ack, while idle
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == IDLE) |-> !bus.stb && !bus.ack);

endmodule

/* src/oled_bit_timer.sv */
`timescale 1ns/1ns

module oled_bit_timer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  soc_pkg::presc_t presc_i,
  input  logic            start_i,
  output logic            sck_o,
  output logic            shift_o,
  output logic            done_o
);

  import soc_pkg::*;

  logic       busy_q;
  logic       sck_q;
  presc_t     hcnt_q;
  logic [2:0] bit_q;
  // last cycle of a high half period
  logic       fall;

  assign fall = busy_q & sck_q & (hcnt_q == presc_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      sck_q  <= 1'b0;
      hcnt_q <= '0;
      bit_q  <= '0;
    end else if (start_i) begin
      // first half period is low, mode 0
      busy_q <= 1'b1;
      sck_q  <= 1'b0;
      hcnt_q <= '0;
      bit_q  <= '0;
    end else if (busy_q) begin
      if (hcnt_q == presc_i) begin
        hcnt_q <= '0;
        sck_q  <= ~sck_q;
        if (sck_q) begin
          bit_q <= bit_q + 1'b1;
          // eighth falling edge ends the byte
          if (bit_q == 3'd7) begin
            busy_q <= 1'b0;
          end
        end
      end else begin
        hcnt_q <= hcnt_q + 1'b1;
      end
    end
  end

  assign sck_o   = sck_q;
  assign shift_o = fall & (bit_q != 3'd7);
  assign done_o  = fall & (bit_q == 3'd7);

  // clock parks low between bytes
  a_sck_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !busy_q |-> !sck_o);

endmodule

/* src/oled_word_serializer.sv */
`timescale 1ns/1ns

module oled_word_serializer (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             load_i,
  input  soc_pkg::wb_dat_t word_i,
  input  logic             next_byte_i,
  input  logic             shift_i,
  output logic             sdo_o,
  output logic             word_end_o
);

  import soc_pkg::*;

  wb_dat_t    word_q;
  logic [1:0] bidx_q;
  logic       end_q;
  logic [7:0] sh_q;

  // word buffer, payload only
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      word_q <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bidx_q <= '0;
      end_q  <= 1'b0;
      sh_q   <= '0;
    end else if (load_i) begin
      bidx_q <= '0;
      end_q  <= 1'b0;
    end else if (next_byte_i) begin
      // lsb byte first, msb of the byte on the wire first
      sh_q   <= word_q[{bidx_q, 3'b000} +: 8];
      bidx_q <= bidx_q + 1'b1;
      end_q  <= (bidx_q == 2'd3);
    end else if (shift_i) begin
      sh_q <= {sh_q[6:0], 1'b0};
    end
  end

  assign sdo_o      = sh_q[7];
  assign word_end_o = end_q;

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ns

module soc_top (
  input  logic             clk_i,
  input  logic             arst_n_i,
  // external host port
  input  logic             host_cyc_i,
  input  logic             host_stb_i,
  input  logic             host_we_i,
  input  soc_pkg::wb_sel_t host_sel_i,
  input  soc_pkg::wb_adr_t host_adr_i,
  input  soc_pkg::wb_dat_t host_dat_i,
  output soc_pkg::wb_dat_t host_dat_o,
  output logic             host_ack_o,
  // gpio
  input  soc_pkg::gpio_t   gpi_i,
  output soc_pkg::gpio_t   gpo_o,
  // oled serial link
  output logic             oled_sck_o,
  output logic             oled_sdo_o
);

  import soc_pkg::*;

  //##########################################################################
  // buses and glue wires
  //##########################################################################

  wb_if host_bus ();
  wb_if dma_bus ();
  wb_if ram_bus ();
  wb_if csr_bus ();

  // csr to dma config
  logic       oled_start;
  presc_t     oled_presc;
  logic       oled_inc;
  wb_adr_t    oled_adr;
  oled_size_t oled_size;
  logic       oled_rdy;
  // byte sequencing
  logic       byte_start;
  logic       byte_done;
  logic       shift;
  logic       word_load;
  logic       next_byte;
  logic       word_end;
  wb_dat_t    word;

  assign host_bus.cyc  = host_cyc_i;
  assign host_bus.stb  = host_stb_i;
  assign host_bus.we   = host_we_i;
  assign host_bus.sel  = host_sel_i;
  assign host_bus.adr  = host_adr_i;
  assign host_bus.wdat = host_dat_i;
  assign host_dat_o    = host_bus.rdat;
  assign host_ack_o    = host_bus.ack;

  // fetched word taken straight off the dma read data
  assign word = dma_bus.rdat;

  //##########################################################################
  // instances
  //##########################################################################

  wb_intercon i_wb_intercon (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .host     ( host_bus ),
    .dma      ( dma_bus  ),
    .ram      ( ram_bus  ),
    .csr      ( csr_bus  )
  );

  wb_ram i_wb_ram (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .bus      ( ram_bus  )
  );

  csr_regs i_csr_regs (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .bus          ( csr_bus    ),
    .gpi_i        ( gpi_i      ),
    .gpo_o        ( gpo_o      ),
    .oled_start_o ( oled_start ),
    .oled_presc_o ( oled_presc ),
    .oled_inc_o   ( oled_inc   ),
    .oled_adr_o   ( oled_adr   ),
    .oled_size_o  ( oled_size  ),
    .oled_rdy_i   ( oled_rdy   )
  );

  oled_dma_fsm i_oled_dma_fsm (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .bus          ( dma_bus    ),
    .start_i      ( oled_start ),
    .inc_i        ( oled_inc   ),
    .adr_i        ( oled_adr   ),
    .size_i       ( oled_size  ),
    .rdy_o        ( oled_rdy   ),
    .byte_start_o ( byte_start ),
    .byte_done_i  ( byte_done  ),
    .word_load_o  ( word_load  ),
    .next_byte_o  ( next_byte  ),
    .word_end_i   ( word_end   )
  );

  oled_bit_timer i_oled_bit_timer (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .presc_i  ( oled_presc ),
    .start_i  ( byte_start ),
    .sck_o    ( oled_sck_o ),
    .shift_o  ( shift      ),
    .done_o   ( byte_done  )
  );

  oled_word_serializer i_oled_word_serializer (
    .clk_i       ( clk_i      ),
    .arst_n_i    ( arst_n_i   ),
    .load_i      ( word_load  ),
    .word_i      ( word       ),
    .next_byte_i ( next_byte  ),
    .shift_i     ( shift      ),
    .sdo_o       ( oled_sdo_o ),
    .word_end_o  ( word_end   )
  );

endmodule

/* bench/tb_soc.sv */
`timescale 1ns/1ns
`include "soc_params.svh"

module tb_soc;

  import soc_pkg::*;

  // wait limits, in clock cycles and in status polls
  localparam int ACK_TMO  = 200;
  localparam int POLL_TMO = 2000;

  logic    clk_i    = 1'b0;
  logic    arst_n_i = 1'b1;
  logic    host_cyc_i;
  logic    host_stb_i;
  logic    host_we_i;
  wb_sel_t host_sel_i;
  wb_adr_t host_adr_i;
  wb_dat_t host_dat_i;
  wb_dat_t host_dat_o;
  logic    host_ack_o;
  gpio_t   gpi_i;
  gpio_t   gpo_o;
  logic    oled_sck_o;
  logic    oled_sdo_o;

  // reference copy of the ram, word indexed
  wb_dat_t    ram_model [`SOC_RAM_DEPTH];
  // bytes seen on the serial link, in order
  logic [7:0] mon_bytes [$];
  // link monitor state
  logic       sck_prev;
  logic [7:0] shreg;
  int         rise_cnt;
  int         gap;
  int         cur_presc;
  // bookkeeping
  int         err_cnt;
  int         chk_cnt;
  int         gap_errs;
  int         gap_checks;
  int         sva_errs;
  int         tests_run;
  int         tests_failed;

  soc_top DUT (.*);

  always #20 clk_i = ~clk_i;

  //##########################################################################
  // helpers
  //##########################################################################

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic check_eq(input string sig, input wb_dat_t exp, input wb_dat_t act);
    chk_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("error: t=%0t %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  function automatic wb_adr_t csr_addr(input csr_idx_e idx);
    return {16'h0, `SOC_REGION_CSR, 7'h0, 3'(idx), 2'b00};
  endfunction

  // ram words sit at byte offset idx*4 in region 0
  function automatic wb_adr_t ram_addr(input int idx);
    return {16'h0, `SOC_REGION_RAM, 12'h0} | (wb_adr_t'(idx % `SOC_RAM_DEPTH) << 2);
  endfunction

  // ack is sampled on the edge, so the value is the one held over the cycle
  task automatic wait_host_ack();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > ACK_TMO) abort_on_timeout("host access got no ack");
    end while (!host_ack_o);
  endtask

  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           input wb_sel_t sel, output wb_dat_t rdat);
    @(posedge clk_i);
    host_cyc_i <= 1'b1;
    host_stb_i <= 1'b1;
    host_we_i  <= we;
    host_sel_i <= sel;
    host_adr_i <= adr;
    host_dat_i <= wdat;
    wait_host_ack();
    rdat = host_dat_o;
    // drop the request right after ack
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
    host_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
    wb_dat_t unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
    bus_cycle(1'b0, adr, '0, 4'hf, dat);
  endtask

  // write through the host port and merge selected lanes into the model
  task automatic ram_write(input int idx, input wb_dat_t dat, input wb_sel_t sel);
    wb_write(ram_addr(idx), dat, sel);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) ram_model[idx][8*b +: 8] = dat[8*b +: 8];
    end
  endtask

  task automatic wait_ready();
    wb_dat_t d;
    int      n;
    n = 0;
    do begin
      wb_read(csr_addr(CSR_OLED_CTRL), d);
      n++;
      if (n > POLL_TMO) abort_on_timeout("oled ready never came back");
    end while (d[0] !== 1'b1);
  endtask

  // lsb byte of each word first, word index fixed when inc is clear
  task automatic check_stream(input int base, input int start, input int n, input bit inc);
    wb_dat_t w;
    check_eq("oled byte count", n, mon_bytes.size() - base);
    for (int k = 0; k < n && base + k < mon_bytes.size(); k++) begin
      w = ram_model[inc ? start + k / 4 : start];
      check_eq("oled_sdo_o byte", 32'(w[8*(k%4) +: 8]), 32'(mon_bytes[base + k]));
    end
  endtask

  //##########################################################################
  // serial link monitor
  //##########################################################################

  // mode 0, data taken on each sck rise, msb first
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      sck_prev = 1'b0;
      rise_cnt = 0;
      gap      = 0;
    end else begin
      gap++;
      if (oled_sck_o && !sck_prev) begin
        shreg = {shreg[6:0], oled_sdo_o};
        // rise to rise spacing only counted inside a byte
        if (rise_cnt != 0) begin
          gap_checks++;
          assert (gap == 2 * (cur_presc + 1)) else begin
            gap_errs++;
            $display("error: t=%0t oled_sck_o period expected %0d actual %0d",
                     $time, 2 * (cur_presc + 1), gap);
          end
        end
        gap = 0;
        rise_cnt++;
        if (rise_cnt == 8) begin
          mon_bytes.push_back(shreg);
          rise_cnt = 0;
        end
      end
      sck_prev = oled_sck_o;
    end
  end

  // data only moves while sck is low
  a_sdo_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    oled_sck_o |-> $stable(oled_sdo_o))
    else begin
      sva_errs++;
      $display("error: t=%0t oled_sdo_o moved while oled_sck_o was high", $time);
    end

  // no ack without a host cycle
  a_ack_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !host_cyc_i |-> !host_ack_o)
    else begin
      sva_errs++;
      $display("error: t=%0t host_ack_o high with no host cycle", $time);
    end

  //##########################################################################
  // test sequence
  //##########################################################################

  initial begin
    wb_dat_t d;
    wb_dat_t v;
    wb_sel_t sel;
    int      idx [8];
    int      e0;
    int      start;
    int      base;
    int      ri;
    void'($urandom(33576));
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
    host_we_i  <= 1'b0;
    host_sel_i <= '0;
    host_adr_i <= '0;
    host_dat_i <= '0;
    gpi_i      <= '0;
    arst_n_i   <= 1'b0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    // 1: values out of reset
    e0 = err_cnt;
    check_eq("oled_sck_o", 0, 32'(oled_sck_o));
    check_eq("gpo_o", 0, 32'(gpo_o));
    check_eq("host_ack_o", 0, 32'(host_ack_o));
    wb_read(csr_addr(CSR_OLED_CTRL), d);
    check_eq("oled ready", 1, d);
    end_test("reset", err_cnt - e0);

    // 2: ram with full and partial writes, then an unmapped read
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      idx[i] = $urandom_range(`SOC_RAM_DEPTH - 1);
      ram_write(idx[i], $urandom, 4'hf);
    end
    for (int i = 0; i < 8; i += 2) begin
      sel = 4'($urandom_range(14, 1));
      ram_write(idx[i], $urandom, sel);
    end
    for (int i = 0; i < 8; i++) begin
      wb_read(ram_addr(idx[i]), d);
      check_eq("host_dat_o", ram_model[idx[i]], d);
    end
    wb_read({16'h0, 4'h3, 12'h0}, d);
    check_eq("host_dat_o unmapped", 0, d);
    end_test("ram", err_cnt - e0);

    // 3: gpio and config readback, truncated to field widths
    e0 = err_cnt;
    v = $urandom;
    wb_write(csr_addr(CSR_GPO), v, 4'hf);
    check_eq("gpo_o", 32'(v[`SOC_GPIO_W-1:0]), 32'(gpo_o));
    v = $urandom;
    gpi_i <= v[`SOC_GPIO_W-1:0];
    wb_read(csr_addr(CSR_GPI), d);
    check_eq("gpi readback", 32'(v[`SOC_GPIO_W-1:0]), d);
    v = $urandom;
    wb_write(csr_addr(CSR_OLED_CONF), v, 4'hf);
    wb_read(csr_addr(CSR_OLED_CONF), d);
    check_eq("oled conf", v & ((32'h1 << (`SOC_PRESC_W + 1)) - 1), d);
    v = $urandom;
    wb_write(csr_addr(CSR_OLED_ADDR), v, 4'hf);
    wb_read(csr_addr(CSR_OLED_ADDR), d);
    check_eq("oled addr", v, d);
    v = $urandom;
    wb_write(csr_addr(CSR_OLED_SIZE), v, 4'hf);
    wb_read(csr_addr(CSR_OLED_SIZE), d);
    check_eq("oled size", v & ((32'h1 << `SOC_OLED_SIZE_W) - 1), d);
    end_test("gpio and csr", err_cnt - e0);

    // 4: dma with address increment, host reads while it runs
    e0 = err_cnt;
    for (int i = 0; i < 64; i++) ram_write(i, $urandom, 4'hf);
    cur_presc = $urandom_range(15);
    start     = $urandom_range(40);
    base      = mon_bytes.size();
    wb_write(csr_addr(CSR_OLED_CONF), 32'(cur_presc) | 32'h10, 4'hf);
    wb_write(csr_addr(CSR_OLED_ADDR), 32'(start), 4'hf);
    wb_write(csr_addr(CSR_OLED_SIZE), 32'd10, 4'hf);
    wb_write(csr_addr(CSR_OLED_CTRL), 32'd1, 4'hf);
    for (int i = 0; i < 3; i++) begin
      ri = $urandom_range(63);
      wb_read(ram_addr(ri), d);
      check_eq("host_dat_o during dma", ram_model[ri], d);
    end
    wait_ready();
    check_stream(base, start, 10, 1'b1);
    end_test("dma increment", err_cnt - e0);

    // 5: fixed address, second start while busy
    e0 = err_cnt;
    cur_presc = $urandom_range(15);
    start     = $urandom_range(63);
    base      = mon_bytes.size();
    wb_write(csr_addr(CSR_OLED_CONF), 32'(cur_presc), 4'hf);
    wb_write(csr_addr(CSR_OLED_ADDR), 32'(start), 4'hf);
    wb_write(csr_addr(CSR_OLED_SIZE), 32'd6, 4'hf);
    wb_write(csr_addr(CSR_OLED_CTRL), 32'd1, 4'hf);
    wb_read(csr_addr(CSR_OLED_CTRL), d);
    check_eq("oled ready while busy", 0, d);
    wb_write(csr_addr(CSR_OLED_CTRL), 32'd1, 4'hf);
    wait_ready();
    // quiet period, a restarted transfer would show up here
    repeat (64) @(posedge clk_i);
    wb_read(csr_addr(CSR_OLED_CTRL), d);
    check_eq("oled ready after idle", 1, d);
    check_stream(base, start, 6, 1'b0);
    end_test("dma fixed address", err_cnt - e0);

    // 6: sck spacing and sdo stability, gathered over tests 4 and 5
    end_test("sck timing", gap_errs + sva_errs + (gap_checks == 0 ? 1 : 0));

    $display("done: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
             tests_failed, chk_cnt + gap_checks, err_cnt + gap_errs + sva_errs);
    if (tests_failed == 0 && err_cnt + gap_errs + sva_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+src
src/soc_pkg.sv
src/wb_if.sv
src/wb_intercon.sv
src/wb_ram.sv
src/csr_regs.sv
src/oled_dma_fsm.sv
src/oled_bit_timer.sv
src/oled_word_serializer.sv
src/soc_top.sv
bench/tb_soc.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_soc
FILELIST := project.f

BUILD := obj_dir
BIN   := $(BUILD)/V$(TOP)
LOG   := sim.log
SRCS  := $(shell grep -v '^+' $(FILELIST))
HDRS  := $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
